//--- Makefile
VERILATOR := verilator
FLAGS     := --timing
TOP       := mips_cpu_tb
RTL_TOP   := mips_cpu_bus
FILELIST  := mips_cpu.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- mips_cpu.f
src/mips_pkg.sv
src/decode_if.sv
src/reg_file_if.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/cpu_control.sv
src/mips_cpu_bus.sv
test/avalon_mem_model.sv
test/mips_cpu_tb.sv

//--- src/alu.sv
// ########################################
// ALU: arithmetic, logic, compare, shift
// ########################################
`timescale 1ns/1ps

module alu import mips_pkg::*; (
    decode_if.sink dec,
    input  word_t  rs_data,
    input  word_t  rt_data,
    output word_t  result,
    output logic   equal
);

    word_t op_b;

    // Second operand is register or immediate
    assign op_b = dec.use_imm ? dec.imm_ext : rt_data;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  result = rs_data + op_b;
            ALU_SUB:  result = rs_data - op_b;
            ALU_AND:  result = rs_data & op_b;
            ALU_OR:   result = rs_data | op_b;
            ALU_XOR:  result = rs_data ^ op_b;
            ALU_SLT:  result = {31'd0, $signed(rs_data) < $signed(op_b)};
            ALU_SLTU: result = {31'd0, rs_data < op_b};
            // Constant shifts act on rt
            ALU_SLL:  result = rt_data << dec.shamt;
            ALU_SRL:  result = rt_data >> dec.shamt;
            ALU_SRA:  result = word_t'($signed(rt_data) >>> dec.shamt);
            ALU_LUI:  result = {dec.imm_ext[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    // Branch compare is always on the two registers
    assign equal = (rs_data == rt_data);

endmodule

//--- src/cpu_control.sv
// ########################################
// CPU control: FSM, PC, instruction
// register and Avalon master sequencing
// ########################################
`timescale 1ns/1ps

module cpu_control import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    decode_if.sink      dec,
    reg_file_if.source  rf,
    input  word_t       alu_result,
    input  logic        alu_equal,
    output word_t       instr,
    output logic        active,

    // Avalon-MM master
    output word_t       address,
    output word_t       writedata,
    output logic        read,
    output logic        write,
    output logic [3:0]  byteenable,
    input  logic        waitrequest,
    input  word_t       readdata
);

    cpu_state_t state;
    cpu_state_t state_next;
    word_t      pc;
    word_t      pc_next;
    word_t      pc_plus4;
    word_t      ir;
    logic       fetch_accept;
    logic       mem_accept;
    logic       branch_taken;

    assign instr = ir;

    // Bus requests
    assign read  = (state == FETCH && active) || (state == MEM && dec.is_load);
    assign write = (state == MEM) && dec.is_store;

    assign address    = (state == MEM) ? alu_result : pc;
    assign writedata  = rf.rt_data;
    assign byteenable = BYTE_ENABLE_ALL;

    assign fetch_accept = (state == FETCH) && read && !waitrequest;
    assign mem_accept   = (state == MEM) && !waitrequest;

    // Next PC
    assign pc_plus4     = pc + 32'd4;
    assign branch_taken = dec.is_branch && (alu_equal == dec.branch_on_equal);

    always_comb begin
        if (dec.is_jump) begin
            pc_next = dec.is_jump_reg ? rf.rs_data
                                      : {pc_plus4[31:28], dec.jump_target, 2'b00};
        end else if (branch_taken) begin
            pc_next = pc_plus4 + {dec.imm_ext[29:0], 2'b00};
        end else begin
            pc_next = pc_plus4;
        end
    end

    // Register write port
    assign rf.rs_addr = dec.rs;
    assign rf.rt_addr = dec.rt;
    assign rf.wr_addr = dec.dest;
    assign rf.wr_data = (state == MEM) ? readdata : alu_result;
    assign rf.wr_en   = (state == EXEC && dec.writes_reg && !dec.is_load)
                        || (mem_accept && dec.is_load);

    always_comb begin
        state_next = state;
        case (state)
            FETCH: begin
                if (fetch_accept) begin
                    state_next = EXEC;
                end
            end
            EXEC: begin
                if (dec.is_load || dec.is_store) begin
                    state_next = MEM;
                end else if (pc_next == HALT_ADDRESS) begin
                    state_next = HALT;
                end else begin
                    state_next = FETCH;
                end
            end
            MEM: begin
                // PC was already advanced in EXEC
                if (mem_accept) begin
                    state_next = (pc == HALT_ADDRESS) ? HALT : FETCH;
                end
            end
            default: state_next = HALT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= FETCH;
            pc     <= RESET_VECTOR;
            active <= 1'b0;
        end else begin
            state  <= state_next;
            active <= (state_next != HALT);
            if (state == EXEC) begin
                pc <= pc_next;
            end
        end
    end

    // Instruction latched on fetch acceptance
    always_ff @(posedge clk) begin
        if (fetch_accept) begin
            ir <= readdata;
        end
    end

endmodule

//--- src/decode_if.sv
// ########################################
// Decoded instruction bundle, from the
// decoder to control and ALU
// ########################################
`timescale 1ns/1ps

interface decode_if import mips_pkg::*; ();
    alu_op_t     alu_op;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   dest;
    word_t       imm_ext;
    logic [4:0]  shamt;
    logic        use_imm;
    logic        writes_reg;
    logic        is_branch;
    logic        branch_on_equal;
    logic        is_jump;
    logic        is_jump_reg;
    logic [25:0] jump_target;
    logic        is_load;
    logic        is_store;

    modport source (output alu_op, rs, rt, dest, imm_ext, shamt, use_imm, writes_reg,
                    is_branch, branch_on_equal, is_jump, is_jump_reg, jump_target,
                    is_load, is_store);
    modport sink (input alu_op, rs, rt, dest, imm_ext, shamt, use_imm, writes_reg,
                  is_branch, branch_on_equal, is_jump, is_jump_reg, jump_target,
                  is_load, is_store);
endinterface

//--- src/instr_decoder.sv
// ########################################
// Instruction decoder
// Splits the word into fields and sets
// the ALU operation and control flags
// ########################################
`timescale 1ns/1ps

module instr_decoder import mips_pkg::*; (
    input  word_t     instr,
    decode_if.source  dec
);

    opcode_t opcode;
    funct_t  funct;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);

    // Plain field extraction
    assign dec.rs          = instr[25:21];
    assign dec.rt          = instr[20:16];
    assign dec.shamt       = instr[10:6];
    assign dec.jump_target = instr[25:0];

    // Logic immediates are zero extended
    assign dec.imm_ext = (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI)
                         ? {16'h0000, instr[15:0]}
                         : {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        // Unknown words fall through as a no-op
        dec.alu_op          = ALU_ADD;
        dec.dest            = instr[15:11];
        dec.use_imm         = 1'b0;
        dec.writes_reg      = 1'b0;
        dec.is_branch       = 1'b0;
        dec.branch_on_equal = 1'b0;
        dec.is_jump         = 1'b0;
        dec.is_jump_reg     = 1'b0;
        dec.is_load         = 1'b0;
        dec.is_store        = 1'b0;

        case (opcode)
            OP_R: begin
                dec.writes_reg = 1'b1;
                case (funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    FN_SRA:  dec.alu_op = ALU_SRA;
                    FN_JR: begin
                        dec.writes_reg  = 1'b0;
                        dec.is_jump     = 1'b1;
                        dec.is_jump_reg = 1'b1;
                    end
                    default: dec.writes_reg = 1'b0;
                endcase
            end
            OP_J:   dec.is_jump = 1'b1;
            OP_BEQ: begin
                dec.is_branch       = 1'b1;
                dec.branch_on_equal = 1'b1;
            end
            OP_BNE: dec.is_branch = 1'b1;
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                dec.dest       = instr[20:16];
                dec.use_imm    = 1'b1;
                dec.writes_reg = 1'b1;
                dec.is_load    = (opcode == OP_LW);
                case (opcode)
                    OP_SLTI:  dec.alu_op = ALU_SLT;
                    OP_SLTIU: dec.alu_op = ALU_SLTU;
                    OP_ANDI:  dec.alu_op = ALU_AND;
                    OP_ORI:   dec.alu_op = ALU_OR;
                    OP_XORI:  dec.alu_op = ALU_XOR;
                    OP_LUI:   dec.alu_op = ALU_LUI;
                    default:  dec.alu_op = ALU_ADD;
                endcase
            end
            OP_SW: begin
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- src/mips_cpu_bus.sv
// ########################################
// Multicycle MIPS CPU with an Avalon-MM
// master port, top level
// ########################################
`timescale 1ns/1ps

module mips_cpu_bus import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,

    // Avalon-MM master
    output word_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    decode_if   dec_bus ();
    reg_file_if rf_bus ();

    word_t instr;
    word_t alu_result;
    logic  alu_equal;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec_bus)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .rf    (rf_bus),
        .v0    (register_v0)
    );

    alu u_alu (
        .dec     (dec_bus),
        .rs_data (rf_bus.rs_data),
        .rt_data (rf_bus.rt_data),
        .result  (alu_result),
        .equal   (alu_equal)
    );

    cpu_control u_control (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec_bus),
        .rf          (rf_bus),
        .alu_result  (alu_result),
        .alu_equal   (alu_equal),
        .instr       (instr),
        .active      (active),
        .address     (address),
        .writedata   (writedata),
        .read        (read),
        .write       (write),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

endmodule

//--- src/mips_pkg.sv
// ########################################
// MIPS CPU package
// Opcodes, function codes, ALU operations,
// FSM states and CPU constants
// ########################################

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Primary opcodes, standard MIPS encodings
    typedef enum logic [5:0] {
        OP_R     = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        HALT  = 2'd3
    } cpu_state_t;

    localparam word_t     RESET_VECTOR    = 32'hbfc0_0000;
    // Jumping here stops the CPU
    localparam word_t     HALT_ADDRESS    = 32'h0000_0000;
    localparam reg_addr_t V0_INDEX        = 5'd2;
    localparam logic [3:0] BYTE_ENABLE_ALL = 4'b1111;

endpackage

//--- src/reg_file.sv
// ########################################
// Register file, 32 x 32 bits
// Register zero is hard-wired to zero
// ########################################
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    reg_file_if.target  rf,
    output word_t       v0
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en && rf.wr_addr != 5'd0) begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

    // Asynchronous reads
    assign rf.rs_data = (rf.rs_addr == 5'd0) ? '0 : regs[rf.rs_addr];
    assign rf.rt_data = (rf.rt_addr == 5'd0) ? '0 : regs[rf.rt_addr];

    assign v0 = regs[V0_INDEX];

endmodule

//--- src/reg_file_if.sv
// ########################################
// Register file access, two read ports
// and one write port
// ########################################
`timescale 1ns/1ps

interface reg_file_if import mips_pkg::*; ();
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    // Control side
    modport source (output rs_addr, rt_addr, wr_en, wr_addr, wr_data,
                    input rs_data, rt_data);
    // Register file side
    modport target (input rs_addr, rt_addr, wr_en, wr_addr, wr_data,
                    output rs_data, rt_data);
endinterface

//--- test/avalon_mem_model.sv
// ########################################
// Avalon-MM word memory slave
// Random waitrequest from a grant input
// ########################################
`timescale 1ns/1ps

module avalon_mem_model import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       grant,
    input  word_t      address,
    input  logic       read,
    input  logic       write,
    input  word_t      writedata,
    input  logic [3:0] byteenable,
    output logic       waitrequest,
    output word_t      readdata
);

    word_t mem [word_t];
    word_t merged;

    initial begin
        waitrequest = 1'b1;
        readdata    = '0;
    end

    // Preload of a single word
    task automatic write_word(input word_t addr, input word_t data);
        mem[addr] = data;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            waitrequest <= 1'b1;
            readdata    <= '0;
        end else if ((read || write) && !waitrequest) begin
            // Transfer accepted on this edge
            waitrequest <= 1'b1;
            if (write) begin
                merged = mem.exists(address) ? mem[address] : '0;
                if (byteenable[0]) merged[7:0]   = writedata[7:0];
                if (byteenable[1]) merged[15:8]  = writedata[15:8];
                if (byteenable[2]) merged[23:16] = writedata[23:16];
                if (byteenable[3]) merged[31:24] = writedata[31:24];
                mem[address] = merged;
            end
        end else if ((read || write) && grant) begin
            waitrequest <= 1'b0;
            readdata    <= mem.exists(address) ? mem[address] : '0;
        end
    end

endmodule

//--- test/mips_cpu_tb.sv
// ########################################
// Testbench for the multicycle MIPS CPU
// Random program, reference model, bus
// protocol checks and watchdog
// ########################################
`timescale 1ns/1ps

module mips_cpu_tb import mips_pkg::*; ();

    logic       clk;
    logic       reset;
    logic       grant;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       write;
    logic       read;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;

    logic [31:0] lfsr_state = 32'h3d6d;
    word_t       prog [64];
    int          prog_len = 0;
    word_t       exp_addr [$];
    word_t       exp_data [$];
    word_t       expected_v0;

    // Monitor state
    logic  held;
    logic  held_read;
    logic  held_write;
    word_t held_address;
    word_t held_writedata;
    logic  seen_request;
    logic  seen_active;
    logic  halted;
    int    store_count;
    int    reset_edges;

    mips_cpu_bus DUT (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    avalon_mem_model mem_model (
        .clk         (clk),
        .reset       (reset),
        .grant       (grant),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic random_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[14:0], random_bit()};
        end
        return bits;
    endfunction

    function automatic word_t rtype_word(input int rs, input int rt, input int rd,
                                         input int sh, input funct_t fn);
        return {OP_R, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t itype_word(input opcode_t op, input int rs, input int rt,
                                         input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t jtype_word(input logic [25:0] field);
        return {OP_J, field};
    endfunction

    task automatic append_instr(input word_t word);
        prog[6'(prog_len)] = word;
        prog_len++;
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("** Error [%s] at %0t: expected %h, actual %h",
                     name, $time, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "check mismatch");
        end
    endtask

    task automatic build_program();
        word_t target;
        // ALU and immediate group
        append_instr(itype_word(OP_ADDIU, 0, 8, random_bits(16)));
        append_instr(itype_word(OP_ORI, 0, 9, random_bits(16)));
        append_instr(itype_word(OP_LUI, 0, 10, random_bits(16)));
        append_instr(rtype_word(8, 9, 11, 0, FN_ADDU));
        append_instr(rtype_word(10, 11, 12, 0, FN_SUBU));
        append_instr(rtype_word(11, 12, 13, 0, FN_AND));
        append_instr(rtype_word(13, 8, 14, 0, FN_OR));
        append_instr(rtype_word(14, 10, 15, 0, FN_XOR));
        append_instr(rtype_word(12, 11, 16, 0, FN_SLT));
        append_instr(rtype_word(12, 11, 17, 0, FN_SLTU));
        append_instr(rtype_word(0, 15, 18, 5, FN_SLL));
        append_instr(rtype_word(0, 15, 19, 7, FN_SRL));
        append_instr(rtype_word(0, 12, 20, 3, FN_SRA));
        append_instr(itype_word(OP_ANDI, 15, 21, random_bits(16)));
        append_instr(itype_word(OP_XORI, 20, 22, random_bits(16)));
        append_instr(itype_word(OP_SLTI, 12, 23, random_bits(16)));
        append_instr(itype_word(OP_SLTIU, 12, 24, random_bits(16)));
        // Store and reload followed by a write to register zero
        append_instr(itype_word(OP_SW, 0, 15, 16'h0100));
        append_instr(itype_word(OP_SW, 0, 20, 16'h0104));
        append_instr(itype_word(OP_LW, 0, 25, 16'h0100));
        append_instr(itype_word(OP_ADDIU, 0, 0, random_bits(16)));
        // Taken and untaken branches guard one instruction each
        append_instr(itype_word(OP_BEQ, 8, 8, 16'd1));
        append_instr(itype_word(OP_ADDIU, 25, 25, 16'd1));
        append_instr(itype_word(OP_BNE, 8, 8, 16'd1));
        append_instr(itype_word(OP_ADDIU, 25, 25, 16'd2));
        append_instr(itype_word(OP_BNE, 8, 10, 16'd1));
        append_instr(itype_word(OP_SW, 0, 25, 16'h0108));
        append_instr(itype_word(OP_BEQ, 11, 12, 16'd1));
        append_instr(itype_word(OP_SW, 0, 21, 16'h010c));
        target = RESET_VECTOR + word_t'(4 * (prog_len + 2));
        append_instr(jtype_word(target[27:2]));
        append_instr(itype_word(OP_SW, 0, 22, 16'h0110));
        // Fold every result into v0 starting from register zero
        append_instr(rtype_word(0, 25, 2, 0, FN_ADDU));
        for (int r = 8; r <= 24; r++) begin
            append_instr(rtype_word(2, r, 2, 0, (r % 2 == 1) ? FN_ADDU : FN_XOR));
        end
        append_instr(itype_word(OP_LW, 0, 3, 16'h0104));
        append_instr(rtype_word(2, 3, 2, 0, FN_ADDU));
        append_instr(rtype_word(0, 0, 0, 0, FN_JR));
    endtask

    // Instruction-set model that returns v0 and records the stores in order
    function automatic word_t reference_run();
        word_t     regs [32];
        word_t     dmem [word_t];
        word_t     pc;
        word_t     idx;
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     imm_s;
        word_t     val;
        word_t     next_pc;
        reg_addr_t dst;
        logic      wr;
        int        steps;
        regs  = '{default: '0};
        pc    = RESET_VECTOR;
        steps = 0;
        while (pc != HALT_ADDRESS && steps < 4 * prog_len) begin
            idx     = (pc - RESET_VECTOR) >> 2;
            ins     = (idx < 64) ? prog[idx[5:0]] : '0;
            a       = regs[ins[25:21]];
            b       = regs[ins[20:16]];
            imm_s   = {{16{ins[15]}}, ins[15:0]};
            next_pc = pc + 32'd4;
            dst     = ins[20:16];
            wr      = 1'b1;
            val     = '0;
            case (ins[31:26])
                OP_R: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        FN_ADDU: val = a + b;
                        FN_SUBU: val = a - b;
                        FN_AND:  val = a & b;
                        FN_OR:   val = a | b;
                        FN_XOR:  val = a ^ b;
                        FN_SLT:  val = {31'd0, $signed(a) < $signed(b)};
                        FN_SLTU: val = {31'd0, a < b};
                        FN_SLL:  val = b << ins[10:6];
                        FN_SRL:  val = b >> ins[10:6];
                        FN_SRA:  val = word_t'($signed(b) >>> ins[10:6]);
                        FN_JR: begin
                            next_pc = a;
                            wr      = 1'b0;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: val = a + imm_s;
                OP_SLTI:  val = {31'd0, $signed(a) < $signed(imm_s)};
                OP_SLTIU: val = {31'd0, a < imm_s};
                OP_ANDI:  val = a & {16'h0000, ins[15:0]};
                OP_ORI:   val = a | {16'h0000, ins[15:0]};
                OP_XORI:  val = a ^ {16'h0000, ins[15:0]};
                OP_LUI:   val = {ins[15:0], 16'h0000};
                OP_LW:    val = dmem.exists(a + imm_s) ? dmem[a + imm_s] : '0;
                OP_SW: begin
                    wr = 1'b0;
                    dmem[a + imm_s] = b;
                    exp_addr.push_back(a + imm_s);
                    exp_data.push_back(b);
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b) next_pc = next_pc + (imm_s << 2);
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (a != b) next_pc = next_pc + (imm_s << 2);
                end
                OP_J: begin
                    wr      = 1'b0;
                    next_pc = {next_pc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) regs[dst] = val;
            pc = next_pc;
            steps++;
        end
        // Register 2 is v0
        return regs[2];
    endfunction

    // Waitrequest grant takes one LFSR bit per cycle
    always @(posedge clk) begin
        grant <= random_bit();
    end

    // Bus protocol and store comparison
    always @(posedge clk) begin
        if (reset) begin
            if (reset_edges > 0) begin
                check_value("read in reset", '0, word_t'(read));
                check_value("write in reset", '0, word_t'(write));
                check_value("active in reset", '0, word_t'(active));
            end
            reset_edges++;
        end else begin
            if (halted) begin
                check_value("read after halt", '0, word_t'(read));
                check_value("write after halt", '0, word_t'(write));
            end
            if ((read || write) && !seen_request) begin
                check_value("first request is read", 32'd1, word_t'(read));
                check_value("first address", 32'hbfc0_0000, address);
                seen_request = 1'b1;
            end
            if (held) begin
                check_value("held address", held_address, address);
                check_value("held read", word_t'(held_read), word_t'(read));
                check_value("held write", word_t'(held_write), word_t'(write));
                if (held_write) check_value("held writedata", held_writedata, writedata);
            end
            held           = (read || write) && waitrequest;
            held_read      = read;
            held_write     = write;
            held_address   = address;
            held_writedata = writedata;
            if (write && !waitrequest) begin
                if (store_count < exp_addr.size()) begin
                    check_value("store address", exp_addr[store_count], address);
                    check_value("store data", exp_data[store_count], writedata);
                    check_value("store byteenable", 32'h0000_000f, word_t'(byteenable));
                end else begin
                    check_value("store count", word_t'(exp_addr.size()),
                                word_t'(store_count + 1));
                end
                store_count++;
            end
            if (active) begin
                seen_active = 1'b1;
            end else if (seen_active) begin
                halted = 1'b1;
            end
        end
    end

    // Watchdog allows 200 cycles per program instruction
    initial begin
        wait (prog_len > 0);
        repeat (prog_len * 200) @(posedge clk);
        $display("Watchdog expired: the CPU did not halt within %0d cycles", prog_len * 200);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        reset        = 1'b1;
        grant        = 1'b0;
        held         = 1'b0;
        held_read    = 1'b0;
        held_write   = 1'b0;
        seen_request = 1'b0;
        seen_active  = 1'b0;
        halted       = 1'b0;
        store_count  = 0;
        reset_edges  = 0;
        build_program();
        for (int i = 0; i < prog_len; i++) begin
            mem_model.write_word(RESET_VECTOR + word_t'(4 * i), prog[6'(i)]);
        end
        expected_v0 = reference_run();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        wait (halted);
        repeat (20) @(posedge clk);
        check_value("final v0", expected_v0, register_v0);
        check_value("store count", word_t'(exp_addr.size()), word_t'(store_count));
        check_value("active after halt", '0, word_t'(active));
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
